/* logic/warp_fe_config.svh */
`ifndef WARP_FE_CONFIG_SVH
`define WARP_FE_CONFIG_SVH

// Warp count and index width
`define WFE_NUM_WARPS 8
`define WFE_WARP_BITS 3

// Word widths
`define WFE_INSTR_BITS 32
`define WFE_PC_BITS 32

// Instruction memory, word addressed
`define WFE_IMEM_WORDS 1024
`define WFE_IMEM_ABITS 10

// Instruction field widths
`define WFE_REG_BITS 5
`define WFE_IMM_BITS 16

`endif

/* logic/warp_fe_pkg.sv */
`include "warp_fe_config.svh"

package warp_fe_pkg;

	// Codes 4'hB..4'hE are unused and decode as NOP
	typedef enum logic [3:0] {
		OP_ADD  = 4'h0,
		OP_SUB  = 4'h1,
		OP_AND  = 4'h2,
		OP_OR   = 4'h3,
		OP_ADDI = 4'h4,
		OP_LD   = 4'h5,
		OP_ST   = 4'h6,
		OP_BEQ  = 4'h7,
		OP_BLT  = 4'h8,
		OP_JMP  = 4'h9,
		OP_EXIT = 4'hA,
		OP_NOP  = 4'hF
	} opcode_t;

	typedef struct packed {
		logic [`WFE_WARP_BITS-1:0]  warp;
		logic [`WFE_PC_BITS-1:0]    pc;
		logic [`WFE_INSTR_BITS-1:0] instr;
	} fetch_slot_t;

	typedef struct packed {
		logic [`WFE_NUM_WARPS-1:0]  warp; // one-hot
		logic [`WFE_PC_BITS-1:0]    pc_plus4;
		logic [`WFE_INSTR_BITS-1:0] instr;
		opcode_t                    opcode;
		logic [`WFE_REG_BITS-1:0]   dst;
		logic [`WFE_REG_BITS-1:0]   src1;
		logic [`WFE_REG_BITS-1:0]   src2;
		logic [`WFE_IMM_BITS-1:0]   imm;
		logic                       src1_valid;
		logic                       src2_valid;
		logic                       imm_valid;
		logic                       reg_write;
		logic                       mem_read;
		logic                       mem_write;
		logic                       is_beq;
		logic                       is_blt;
		logic                       is_jmp;
		logic                       is_exit;
	} decoded_t;

	typedef struct packed {
		logic                    valid;
		logic [`WFE_PC_BITS-1:0] target;
	} redirect_t;

	typedef struct packed {
		logic                      valid;
		logic [`WFE_WARP_BITS-1:0] warp;
		logic [`WFE_PC_BITS-1:0]   pc;
	} launch_t;

endpackage

/* logic/stage_reg.sv */
`timescale 1ns/1ps

module stage_reg #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     in_valid,
	input  payload_t in_data,
	output logic     out_valid,
	output payload_t out_data
);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= in_valid;
		end
	end

	// Payload holds its last value when idle
	always_ff @(posedge clk) begin
		if (in_valid) begin
			out_data <= in_data;
		end
	end

endmodule

/* logic/warp_pc.sv */
`timescale 1ns/1ps

`include "warp_fe_config.svh"

module warp_pc (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          launch_en,
	input  logic [`WFE_PC_BITS-1:0]       start_pc,
	input  logic                          advance,
	input  logic                          retire,
	input  logic                          jump_en,
	input  logic [`WFE_PC_BITS-1:0]       jump_target,
	input  warp_fe_pkg::redirect_t        redirect,
	output logic                          active,
	output logic                          busy,
	output logic [`WFE_PC_BITS-1:0]       pc
);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			active <= 1'b0;
			busy   <= 1'b0;
			pc     <= '0;
		end else begin
			// In flight for exactly the decode cycle
			busy <= advance;
			if (launch_en) begin
				active <= 1'b1;
				pc     <= start_pc;
			end else if (retire) begin
				active <= 1'b0;
			end else if (jump_en) begin
				pc <= jump_target;
			end else if (redirect.valid) begin
				pc <= redirect.target; // branch outcome from outside
			end else if (advance) begin
				pc <= pc + `WFE_PC_BITS'(4);
			end
		end
	end

	// Arbiter must only pick a running warp with nothing in decode
	a_advance_legal: assert property (
		@(posedge clk) disable iff (!rst_n)
		advance |-> (active && !busy)
	) else $error("warp_pc: advance while busy or inactive");

	// Decode feedback comes one cycle after the grant
	a_feedback_after_grant: assert property (
		@(posedge clk) disable iff (!rst_n)
		(jump_en || retire) |-> $past(advance)
	) else $error("warp_pc: jump or exit without a prior grant");

endmodule

/* logic/dual_grant_arbiter.sv */
`timescale 1ns/1ps

`include "warp_fe_config.svh"

module dual_grant_arbiter (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic [`WFE_NUM_WARPS-1:0] eligible,
	output logic [`WFE_NUM_WARPS-1:0] grant0,
	output logic [`WFE_NUM_WARPS-1:0] grant1
);

	localparam int N  = `WFE_NUM_WARPS;
	localparam int WB = `WFE_WARP_BITS;

	logic [WB-1:0]  ptr;
	logic [N-1:0]   rot;
	logic [2*N-1:0] dbl;
	logic [WB-1:0]  off0, off1;
	logic [WB-1:0]  idx0, idx1;
	logic           hit0, hit1;

	always_comb begin
		// Rotate so the pointer warp sits at bit 0
		dbl  = {eligible, eligible} >> ptr;
		rot  = dbl[N-1:0];
		hit0 = 1'b0;
		off0 = '0;
		for (int i = 0; i < N; i++) begin
			if (rot[i] && !hit0) begin
				hit0 = 1'b1;
				off0 = WB'(i);
			end
		end
		hit1 = 1'b0;
		off1 = '0;
		for (int i = 0; i < N; i++) begin
			if (rot[i] && hit0 && !hit1 && (i > int'(off0))) begin
				hit1 = 1'b1;
				off1 = WB'(i);
			end
		end
		idx0 = ptr + off0; // wraps modulo warp count
		idx1 = ptr + off1;
		grant0 = '0;
		grant1 = '0;
		if (hit0) begin
			grant0[idx0] = 1'b1;
		end
		if (hit1) begin
			grant1[idx1] = 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ptr <= '0;
		end else if (hit1) begin
			ptr <= idx1 + WB'(1);
		end else if (hit0) begin
			ptr <= idx0 + WB'(1);
		end
	end

	a_disjoint: assert property (@(posedge clk) disable iff (!rst_n)
		(grant0 & grant1) == '0
	) else $error("arbiter: both slots granted the same warp");

	a_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(grant0) && $onehot0(grant1)
	) else $error("arbiter: grant not one-hot");

	a_slot_order: assert property (@(posedge clk) disable iff (!rst_n)
		(grant1 != '0) |-> (grant0 != '0)
	) else $error("arbiter: slot 1 granted without slot 0");

endmodule

/* logic/instr_fetch.sv */
`timescale 1ns/1ps

`include "warp_fe_config.svh"

module instr_fetch (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           imem_wen,
	input  logic [`WFE_IMEM_ABITS-1:0]     imem_addr,
	input  logic [`WFE_INSTR_BITS-1:0]     imem_wdata,
	output logic [`WFE_INSTR_BITS-1:0]     imem_rdata,
	input  logic [`WFE_PC_BITS-1:0]        pcs [`WFE_NUM_WARPS],
	input  logic [`WFE_NUM_WARPS-1:0]      grant0,
	input  logic [`WFE_NUM_WARPS-1:0]      grant1,
	output warp_fe_pkg::fetch_slot_t       slot0,
	output warp_fe_pkg::fetch_slot_t       slot1,
	output logic                           slot0_valid,
	output logic                           slot1_valid
);

	import warp_fe_pkg::*;

	localparam int N  = `WFE_NUM_WARPS;
	localparam int WB = `WFE_WARP_BITS;
	localparam int AB = `WFE_IMEM_ABITS;

	logic [`WFE_INSTR_BITS-1:0] imem [`WFE_IMEM_WORDS];

	logic [`WFE_PC_BITS-1:0] pc0, pc1;
	logic [WB-1:0]           w0, w1;
	fetch_slot_t             fetch0, fetch1;

	// Load port, read data one cycle after the address
	always_ff @(posedge clk) begin
		if (imem_wen) begin
			imem[imem_addr] <= imem_wdata;
		end
		imem_rdata <= imem[imem_addr];
	end

	// One-hot grants select the warp PC
	always_comb begin
		pc0 = '0;
		pc1 = '0;
		w0  = '0;
		w1  = '0;
		for (int i = 0; i < N; i++) begin
			if (grant0[i]) begin
				pc0 = pcs[i];
				w0  = WB'(i);
			end
			if (grant1[i]) begin
				pc1 = pcs[i];
				w1  = WB'(i);
			end
		end
	end

	always_comb begin
		fetch0.warp  = w0;
		fetch0.pc    = pc0;
		fetch0.instr = imem[pc0[AB+1:2]]; // word address
		fetch1.warp  = w1;
		fetch1.pc    = pc1;
		fetch1.instr = imem[pc1[AB+1:2]];
	end

	stage_reg #(.payload_t(fetch_slot_t)) u_slot0_reg (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_valid (|grant0),
		.in_data  (fetch0),
		.out_valid(slot0_valid),
		.out_data (slot0)
	);

	stage_reg #(.payload_t(fetch_slot_t)) u_slot1_reg (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_valid (|grant1),
		.in_data  (fetch1),
		.out_valid(slot1_valid),
		.out_data (slot1)
	);

endmodule

/* logic/instr_decode.sv */
`timescale 1ns/1ps

`include "warp_fe_config.svh"

module instr_decode (
	input  logic                      in_valid,
	input  warp_fe_pkg::fetch_slot_t  fetched,
	output logic                      out_valid,
	output warp_fe_pkg::decoded_t     decoded,
	output logic [`WFE_NUM_WARPS-1:0] jmp_warp,
	output logic [`WFE_NUM_WARPS-1:0] exit_warp,
	output logic [`WFE_PC_BITS-1:0]   jump_target
);

	import warp_fe_pkg::*;

	opcode_t op;

	always_comb begin
		op = opcode_t'(fetched.instr[31:28]);
		decoded = '0;
		decoded.warp[fetched.warp] = 1'b1;
		decoded.pc_plus4 = fetched.pc + `WFE_PC_BITS'(4);
		decoded.instr    = fetched.instr;
		decoded.opcode   = op;
		decoded.dst      = fetched.instr[27:23];
		decoded.src1     = fetched.instr[22:18];
		decoded.src2     = fetched.instr[17:13];
		decoded.imm      = fetched.instr[15:0]; // overlaps src2
		case (op)
			OP_ADD, OP_SUB, OP_AND, OP_OR: begin
				decoded.reg_write  = 1'b1;
				decoded.src1_valid = 1'b1;
				decoded.src2_valid = 1'b1;
			end
			OP_ADDI: begin
				decoded.reg_write  = 1'b1;
				decoded.src1_valid = 1'b1;
				decoded.imm_valid  = 1'b1;
			end
			OP_LD: begin
				decoded.reg_write  = 1'b1;
				decoded.mem_read   = 1'b1;
				decoded.src1_valid = 1'b1;
				decoded.imm_valid  = 1'b1;
			end
			OP_ST: begin
				decoded.mem_write  = 1'b1;
				decoded.src1_valid = 1'b1;
				decoded.src2_valid = 1'b1;
				decoded.imm_valid  = 1'b1;
			end
			OP_BEQ, OP_BLT: begin
				decoded.src1_valid = 1'b1;
				decoded.src2_valid = 1'b1;
				decoded.imm_valid  = 1'b1;
				decoded.is_beq     = (op == OP_BEQ);
				decoded.is_blt     = (op == OP_BLT);
			end
			OP_JMP: begin
				decoded.imm_valid = 1'b1;
				decoded.is_jmp    = 1'b1;
			end
			OP_EXIT: decoded.is_exit = 1'b1;
			OP_NOP: ;
			default: decoded.opcode = OP_NOP; // unused codes
		endcase
	end

	assign out_valid   = in_valid;
	assign jump_target = {{(`WFE_PC_BITS-18){1'b0}}, fetched.instr[15:0], 2'b00};
	assign jmp_warp    = (in_valid && decoded.is_jmp) ? decoded.warp : '0;
	assign exit_warp   = (in_valid && decoded.is_exit) ? decoded.warp : '0;

endmodule

/* logic/warp_front_end.sv */
`timescale 1ns/1ps

`include "warp_fe_config.svh"

module warp_front_end (
	input  logic                       clk,
	input  logic                       rst_n,
	// Instruction memory load port
	input  logic                       imem_wen,
	input  logic [`WFE_IMEM_ABITS-1:0] imem_addr,
	input  logic [`WFE_INSTR_BITS-1:0] imem_wdata,
	output logic [`WFE_INSTR_BITS-1:0] imem_rdata,
	// Warp control
	input  warp_fe_pkg::launch_t       launch,
	input  logic [`WFE_NUM_WARPS-1:0]  ib_req,
	input  logic [`WFE_NUM_WARPS-1:0]  warp_stall,
	input  warp_fe_pkg::redirect_t     redirect [`WFE_NUM_WARPS],
	// Issue slots to the instruction buffer
	output warp_fe_pkg::decoded_t      slot0,
	output logic                       slot0_valid,
	output warp_fe_pkg::decoded_t      slot1,
	output logic                       slot1_valid
);

	import warp_fe_pkg::*;

	localparam int N  = `WFE_NUM_WARPS;
	localparam int WB = `WFE_WARP_BITS;

	logic [N-1:0]            active, busy, eligible;
	logic [N-1:0]            grant0, grant1;
	logic [`WFE_PC_BITS-1:0] pcs [N];

	fetch_slot_t fetch0, fetch1;
	logic        fetch0_valid, fetch1_valid;

	decoded_t                dec0, dec1;
	logic                    dec0_valid, dec1_valid;
	logic [N-1:0]            jmp0, jmp1, exit0, exit1;
	logic [`WFE_PC_BITS-1:0] tgt0, tgt1;

	assign eligible = active & ~busy & ib_req & ~warp_stall;

	for (genvar i = 0; i < N; i++) begin : g_warp
		warp_pc u_pc (
			.clk        (clk),
			.rst_n      (rst_n),
			.launch_en  (launch.valid && (launch.warp == WB'(i))),
			.start_pc   (launch.pc),
			.advance    (grant0[i] | grant1[i]),
			.retire     (exit0[i] | exit1[i]), // disjoint per slot
			.jump_en    (jmp0[i] | jmp1[i]),
			.jump_target(jmp0[i] ? tgt0 : tgt1),
			.redirect   (redirect[i]),
			.active     (active[i]),
			.busy       (busy[i]),
			.pc         (pcs[i])
		);
	end

	dual_grant_arbiter u_arb (
		.clk     (clk),
		.rst_n   (rst_n),
		.eligible(eligible),
		.grant0  (grant0),
		.grant1  (grant1)
	);

	instr_fetch u_fetch (
		.clk        (clk),
		.rst_n      (rst_n),
		.imem_wen   (imem_wen),
		.imem_addr  (imem_addr),
		.imem_wdata (imem_wdata),
		.imem_rdata (imem_rdata),
		.pcs        (pcs),
		.grant0     (grant0),
		.grant1     (grant1),
		.slot0      (fetch0),
		.slot1      (fetch1),
		.slot0_valid(fetch0_valid),
		.slot1_valid(fetch1_valid)
	);

	instr_decode u_dec0 (
		.in_valid   (fetch0_valid),
		.fetched    (fetch0),
		.out_valid  (dec0_valid),
		.decoded    (dec0),
		.jmp_warp   (jmp0),
		.exit_warp  (exit0),
		.jump_target(tgt0)
	);

	instr_decode u_dec1 (
		.in_valid   (fetch1_valid),
		.fetched    (fetch1),
		.out_valid  (dec1_valid),
		.decoded    (dec1),
		.jmp_warp   (jmp1),
		.exit_warp  (exit1),
		.jump_target(tgt1)
	);

	stage_reg #(.payload_t(decoded_t)) u_out0 (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_valid (dec0_valid),
		.in_data  (dec0),
		.out_valid(slot0_valid),
		.out_data (slot0)
	);

	stage_reg #(.payload_t(decoded_t)) u_out1 (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_valid (dec1_valid),
		.in_data  (dec1),
		.out_valid(slot1_valid),
		.out_data (slot1)
	);

	// Grant to issue output is exactly two cycles
	a_grant_latency: assert property (
		@(posedge clk) disable iff (!rst_n)
		(grant0 != '0) |-> ##2 (slot0_valid && (slot0.warp == $past(grant0, 2)))
	) else $error("warp_front_end: slot 0 output not two cycles after grant");

endmodule

/* verif/warp_fe_tb.sv */
`timescale 1ns/1ps

`include "warp_fe_config.svh"

module warp_fe_tb;

	import warp_fe_pkg::*;

	localparam int N = `WFE_NUM_WARPS;
	localparam int AB = `WFE_IMEM_ABITS;
	localparam int LOAD_CYCLES = 300;
	localparam time WATCHDOG_NS = (6 * 200 + LOAD_CYCLES) * 20;

	logic clk;
	logic rst_n;
	logic imem_wen;
	logic [AB-1:0] imem_addr;
	logic [31:0] imem_wdata;
	logic [31:0] imem_rdata;
	launch_t launch;
	logic [N-1:0] ib_req;
	logic [N-1:0] warp_stall;
	redirect_t redirect [N];
	decoded_t slot0;
	decoded_t slot1;
	logic slot0_valid;
	logic slot1_valid;

	logic [31:0] mem_model [`WFE_IMEM_WORDS]; // Mirror of every word loaded
	logic [31:0] lfsr = 32'h9581_c0d3;
	logic [31:0] exp_pc [N]; // Next PC each warp should deliver
	logic exited [N];
	int out_count [N];
	int last_cyc [N];
	int cycle = 0;
	int launch_cyc;
	int slot1_uses = 0;
	int checks = 0;
	int errors = 0;
	bit check_gap = 1'b0;

	warp_front_end UUT (
		.clk        (clk),
		.rst_n      (rst_n),
		.imem_wen   (imem_wen),
		.imem_addr  (imem_addr),
		.imem_wdata (imem_wdata),
		.imem_rdata (imem_rdata),
		.launch     (launch),
		.ib_req     (ib_req),
		.warp_stall (warp_stall),
		.redirect   (redirect),
		.slot0      (slot0),
		.slot0_valid(slot0_valid),
		.slot1      (slot1),
		.slot1_valid(slot1_valid)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) cycle <= cycle + 1;

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] rand_bits(int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
		end
		return r;
	endfunction

	function automatic logic [31:0] enc_r(opcode_t op, int d, int s1, int s2);
		return {op, 5'(d), 5'(s1), 5'(s2), 13'b0};
	endfunction

	function automatic logic [31:0] enc_i(opcode_t op, int d, int s1, int imm);
		return {op, 5'(d), 5'(s1), 2'b00, 16'(imm)};
	endfunction

	// Expected issue payload from the decode table
	function automatic decoded_t ref_decode(logic [31:0] instr, int w, logic [31:0] pc);
		decoded_t d;
		d = '0;
		d.warp = 8'(1) << w;
		d.pc_plus4 = pc + 32'd4;
		d.instr = instr;
		d.opcode = opcode_t'(instr[31:28]);
		d.dst = instr[27:23];
		d.src1 = instr[22:18];
		d.src2 = instr[17:13];
		d.imm = instr[15:0];
		case (instr[31:28])
			4'h0, 4'h1, 4'h2, 4'h3: {d.reg_write, d.src1_valid, d.src2_valid} = 3'b111;
			4'h4: {d.reg_write, d.src1_valid, d.imm_valid} = 3'b111;
			4'h5: {d.reg_write, d.mem_read, d.src1_valid, d.imm_valid} = 4'hF;
			4'h6: {d.mem_write, d.src1_valid, d.src2_valid, d.imm_valid} = 4'hF;
			4'h7: {d.is_beq, d.src1_valid, d.src2_valid, d.imm_valid} = 4'hF;
			4'h8: {d.is_blt, d.src1_valid, d.src2_valid, d.imm_valid} = 4'hF;
			4'h9: {d.is_jmp, d.imm_valid} = 2'b11;
			4'hA: d.is_exit = 1'b1;
			default: d.opcode = OP_NOP;
		endcase
		return d;
	endfunction

	task automatic check_eq(string name, logic [127:0] got, logic [127:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("CHECK FAILED time=%0t %s expected %h got %h", $time, name, exp, got);
		end
	endtask

	task automatic report_error(string what);
		checks++;
		assert (1'b0) else begin
			errors++;
			$display("ERROR time=%0t %s", $time, what);
		end
	endtask

	task automatic check_slot(decoded_t s, string name);
		int w;
		logic [31:0] pc;
		decoded_t e;
		w = 0;
		if (!$onehot(s.warp)) begin
			report_error({name, " warp field is not one-hot"});
			return;
		end
		for (int i = 0; i < N; i++) if (s.warp[i]) w = i;
		if (exited[w]) report_error($sformatf("%s output from warp %0d after EXIT", name, w));
		pc = exp_pc[w];
		e = ref_decode(mem_model[pc[AB+1:2]], w, pc);
		check_eq({name, ".pc_plus4"}, 128'(s.pc_plus4), 128'(pc + 32'd4));
		check_eq(name, 128'(s), 128'(e));
		exp_pc[w] = e.is_jmp ? {14'b0, e.imm, 2'b00} : pc + 32'd4;
		if (e.is_exit) exited[w] = 1'b1;
		if (check_gap && out_count[w] > 0) begin
			check_eq("issue gap cycles", 128'(cycle - last_cyc[w]), 128'(2));
		end
		last_cyc[w] = cycle;
		out_count[w]++;
	endtask

	// Output monitor, sampled away from the active edge
	always @(negedge clk) begin
		if (rst_n) begin
			if (slot0_valid) check_slot(slot0, "slot0");
			if (slot1_valid) begin
				slot1_uses++;
				if (!slot0_valid) report_error("slot1 valid while slot0 idle");
				if (slot0_valid && slot0.warp == slot1.warp)
					report_error("both slots carry the same warp");
				check_slot(slot1, "slot1");
			end
		end
	end

	task automatic load_word(int addr, logic [31:0] data);
		@(negedge clk);
		imem_wen = 1'b1;
		imem_addr = AB'(addr);
		imem_wdata = data;
		mem_model[addr] = data;
	endtask

	task automatic load_done();
		@(negedge clk);
		imem_wen = 1'b0;
	endtask

	task automatic launch_warp(int w, logic [31:0] pc);
		@(negedge clk);
		launch.valid = 1'b1;
		launch.warp = 3'(w);
		launch.pc = pc;
		exp_pc[w] = pc;
		exited[w] = 1'b0;
		@(posedge clk);
		#1 launch_cyc = cycle;
		@(negedge clk);
		launch.valid = 1'b0;
	endtask

	task automatic wait_count(int w, int target, int limit);
		int i;
		i = 0;
		while (out_count[w] < target && i < limit) begin
			@(posedge clk);
			i++;
		end
		if (out_count[w] < target)
			report_error($sformatf("warp %0d stopped producing outputs", w));
	endtask

	task automatic idle(int n);
		repeat (n) @(posedge clk);
	endtask

	task automatic test_done(string name, int err_before);
		$display("%s finished with %0d errors", name, errors - err_before);
	endtask

	task automatic test_mem_load();
		int e0;
		e0 = errors;
		for (int i = 0; i < 32; i++) load_word(i, rand_bits(32));
		load_done();
		for (int i = 0; i < 32; i++) begin
			@(negedge clk);
			imem_addr = AB'(i);
			@(negedge clk);
			check_eq("imem_rdata", 128'(imem_rdata), 128'(mem_model[i]));
		end
		test_done("memory load", e0);
	endtask

	task automatic test_straight_line();
		int e0;
		int base;
		e0 = errors;
		base = out_count[2];
		load_word(64, enc_r(OP_ADD, 1, 2, 3));
		load_word(65, enc_i(OP_ADDI, 4, 1, 16'h0010));
		load_word(66, enc_i(OP_LD, 5, 4, 8));
		load_word(67, enc_r(OP_ST, 0, 5, 4));
		load_word(68, enc_r(OP_BEQ, 0, 1, 2));
		load_word(69, enc_r(OP_BLT, 0, 3, 4));
		load_word(70, enc_r(OP_EXIT, 0, 0, 0));
		load_done();
		check_gap = 1'b1; // Solitary warp issues every 2 cycles
		ib_req[2] = 1'b1;
		launch_warp(2, 32'h100);
		wait_count(2, base + 1, 20);
		check_eq("grant to output cycles", 128'(last_cyc[2] - launch_cyc), 128'(2));
		wait_count(2, base + 7, 40);
		idle(6);
		check_eq("warp 2 output count", 128'(out_count[2]), 128'(base + 7));
		check_gap = 1'b0;
		ib_req[2] = 1'b0;
		test_done("straight-line warp", e0);
	endtask

	task automatic test_jmp_exit();
		int e0;
		int base;
		e0 = errors;
		base = out_count[3];
		load_word(128, enc_i(OP_ADDI, 2, 3, 7));
		load_word(129, enc_i(OP_JMP, 0, 0, 140)); // to byte 0x230
		load_word(130, enc_r(OP_ADD, 9, 9, 9));
		load_word(140, enc_r(OP_SUB, 3, 4, 5));
		load_word(141, enc_r(OP_EXIT, 0, 0, 0));
		load_done();
		ib_req[3] = 1'b1;
		launch_warp(3, 32'h200);
		wait_count(3, base + 4, 40);
		idle(10);
		check_eq("warp 3 output count", 128'(out_count[3]), 128'(base + 4));
		check_eq("warp 3 next pc", 128'(exp_pc[3]), 128'(32'h238));
		ib_req[3] = 1'b0;
		test_done("jmp and exit", e0);
	endtask

	task automatic test_dual_issue();
		int e0;
		int snap [4];
		int cnt;
		int lo;
		int hi;
		int uses0;
		int ws [4];
		e0 = errors;
		ws = '{0, 4, 5, 6};
		for (int i = 256; i < 320; i++)
			load_word(i, enc_r(opcode_t'(4'(rand_bits(2))), rand_bits(5), rand_bits(5),
				rand_bits(5)));
		load_done();
		for (int k = 0; k < 4; k++) begin
			ib_req[ws[k]] = 1'b1;
			launch_warp(ws[k], 32'h400);
		end
		idle(6);
		uses0 = slot1_uses;
		for (int k = 0; k < 4; k++) snap[k] = out_count[ws[k]];
		idle(40);
		lo = 1000;
		hi = 0;
		for (int k = 0; k < 4; k++) begin
			cnt = out_count[ws[k]] - snap[k];
			if (cnt < lo) lo = cnt;
			if (cnt > hi) hi = cnt;
		end
		if (hi - lo > 1) report_error($sformatf("unfair grants, counts %0d to %0d", lo, hi));
		if (lo == 0) report_error("a launched warp made no progress");
		if (slot1_uses == uses0) report_error("slot1 never used with four warps ready");
		@(negedge clk);
		ib_req = '0;
		idle(4);
		test_done("dual issue and fairness", e0);
	endtask

	task automatic test_stall_req();
		int e0;
		int c;
		e0 = errors;
		ib_req[1] = 1'b1;
		launch_warp(1, 32'h400);
		wait_count(1, out_count[1] + 3, 20);
		@(negedge clk);
		warp_stall[1] = 1'b1;
		@(posedge clk);
		c = out_count[1];
		idle(10);
		if (out_count[1] > c + 1) report_error("warp 1 issued while stalled");
		@(negedge clk);
		warp_stall[1] = 1'b0;
		wait_count(1, out_count[1] + 2, 20);
		@(negedge clk);
		ib_req[1] = 1'b0;
		@(posedge clk);
		c = out_count[1];
		idle(10);
		if (out_count[1] > c + 1) report_error("warp 1 issued without a request");
		@(negedge clk);
		ib_req[1] = 1'b1;
		wait_count(1, out_count[1] + 2, 20);
		@(negedge clk);
		ib_req[1] = 1'b0;
		idle(4);
		test_done("stall and request", e0);
	endtask

	task automatic test_random_redirect();
		int e0;
		logic [3:0] code;
		e0 = errors;
		for (int i = 512; i < 640; i++) begin
			code = 4'(rand_bits(4));
			while (code == 4'h9 || code == 4'hA) code = 4'(rand_bits(4));
			load_word(i, {code, 28'(rand_bits(28))});
		end
		load_done();
		ib_req[2] = 1'b1;
		ib_req[3] = 1'b1;
		launch_warp(2, 32'h800);
		launch_warp(3, 32'h900);
		idle(30);
		@(negedge clk);
		ib_req[2] = 1'b0;
		idle(4); // Let warp 2 drain
		@(negedge clk);
		redirect[2].valid = 1'b1;
		redirect[2].target = 32'h880;
		exp_pc[2] = 32'h880;
		@(negedge clk);
		redirect[2].valid = 1'b0;
		ib_req[2] = 1'b1;
		wait_count(2, out_count[2] + 5, 20);
		idle(10);
		@(negedge clk);
		ib_req = '0;
		idle(4);
		test_done("random decode and redirect", e0);
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the tests did not complete in time");
		$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		rst_n = 1'b0;
		imem_wen = 1'b0;
		imem_addr = '0;
		imem_wdata = '0;
		launch = '0;
		ib_req = '0;
		warp_stall = '0;
		for (int i = 0; i < N; i++) begin
			redirect[i] = '0;
			exp_pc[i] = '0;
			exited[i] = 1'b0;
			out_count[i] = 0;
			last_cyc[i] = 0;
		end
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		test_mem_load();
		test_straight_line();
		test_jmp_exit();
		test_dual_issue();
		test_stall_req();
		test_random_redirect();
		$display("Checks run %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

/* src.f */
+incdir+logic
logic/warp_fe_pkg.sv
logic/stage_reg.sv
logic/warp_pc.sv
logic/dual_grant_arbiter.sv
logic/instr_fetch.sv
logic/instr_decode.sv
logic/warp_front_end.sv
verif/warp_fe_tb.sv

/* run.sh */
#!/bin/sh
# Build with Verilator and run, pass only if the pass message is printed
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module warp_fe_tb -o warp_fe_sim \
	&& ./obj_dir/warp_fe_sim | tee /dev/stderr | grep -q "ALL CHECKS PASSED" \
	&& echo "run.sh: simulation passed" \
	|| { echo "run.sh: simulation failed"; exit 1; }
